/* mcu_pkg.sv */
// shared address map, register offsets and bus types for the mini MCU
// imported by every module and interface of the design

package mcu_pkg;

  typedef logic [31:0] addr_t;
  typedef logic [31:0] data_t;
  typedef logic [3:0]  region_t;
  typedef logic [31:0] intr_t;

  // address bits 31..28 pick the region
  localparam region_t REGION_RAM    = 4'h0;
  localparam region_t REGION_AO     = 4'h2;
  localparam region_t REGION_PERIPH = 4'h3;

  localparam int unsigned NUM_BANKS  = 4;
  localparam int unsigned BANK_WORDS = 16;

  // gpio block sits at this offset inside each peripheral subsystem
  localparam addr_t GPIO_OFFSET = 32'h0000_0100;

  // soc control
  localparam addr_t EXIT_VALID_OFF  = 32'h00;
  localparam addr_t EXIT_VALUE_OFF  = 32'h04;
  localparam addr_t BOOT_SELECT_OFF = 32'h08;

  localparam addr_t MSIP_OFF = 32'h00;

  // gpio, relative to GPIO_OFFSET
  localparam addr_t GPIO_IN_OFF          = 32'h00;
  localparam addr_t GPIO_OUT_OFF         = 32'h04;
  localparam addr_t GPIO_OE_OFF          = 32'h08;
  localparam addr_t GPIO_INTR_EN_OFF     = 32'h0C;
  localparam addr_t GPIO_INTR_STATUS_OFF = 32'h10;

  // interrupt vector layout
  localparam int unsigned IRQ_SOFTWARE_BIT = 3;
  localparam int unsigned IRQ_EXTERNAL_BIT = 11;
  localparam int unsigned IRQ_FAST_LSB     = 16;

  localparam int unsigned NUM_AO_GPIO = 8;
  localparam int unsigned NUM_GPIO    = 32;

endpackage

/* apb_if.sv */
// APB connection between the system bus and one slave subsystem
// the bus drives the master modport, each subsystem takes the slave modport
`timescale 1ns/1ps

interface apb_if;
  import mcu_pkg::*;

  addr_t paddr;
  logic  psel;
  logic  penable;
  logic  pwrite;
  data_t pwdata;
  data_t prdata;
  logic  pready;
  logic  pslverr;

  modport master (
    output paddr, psel, penable, pwrite, pwdata,
    input  prdata, pready, pslverr
  );

  modport slave (
    input  paddr, psel, penable, pwrite, pwdata,
    output prdata, pready, pslverr
  );

endinterface

/* gpio_bank.sv */
// GPIO register block: output, output enable, interrupt enable and sticky status
// pins pass a two-flop synchronizer, rising edges set the status bits
`timescale 1ns/1ps

module gpio_bank #(
  parameter int unsigned NUM_PINS = 8
) (
  input  logic                clk_i,
  input  logic                rst_n_i,
  input  logic                sel_i,
  input  logic                write_i,
  input  mcu_pkg::addr_t      offset_i,
  input  mcu_pkg::data_t      wdata_i,
  output mcu_pkg::data_t      rdata_o,
  input  logic [NUM_PINS-1:0] pins_i,
  output logic [NUM_PINS-1:0] pins_o,
  output logic [NUM_PINS-1:0] pins_oe_o,
  output logic [NUM_PINS-1:0] intr_o
);
  import mcu_pkg::*;

  logic [NUM_PINS-1:0] sync1_q;
  logic [NUM_PINS-1:0] sync2_q;
  logic [NUM_PINS-1:0] prev_q;
  logic [NUM_PINS-1:0] rise;
  logic [NUM_PINS-1:0] out_q;
  logic [NUM_PINS-1:0] oe_q;
  logic [NUM_PINS-1:0] intr_en_q;
  logic [NUM_PINS-1:0] status_q;
  logic [NUM_PINS-1:0] status_clr;
  logic [NUM_PINS-1:0] wdata;
  logic                wr_en;

  assign wr_en = sel_i && write_i;
  assign wdata = wdata_i[NUM_PINS-1:0];

  // third stage only remembers the last synchronized level
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      sync1_q <= '0;
      sync2_q <= '0;
      prev_q  <= '0;
    end else begin
      sync1_q <= pins_i;
      sync2_q <= sync1_q;
      prev_q  <= sync2_q;
    end
  end

  assign rise = sync2_q & ~prev_q;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      out_q     <= '0;
      oe_q      <= '0;
      intr_en_q <= '0;
    end else if (wr_en) begin
      case (offset_i)
        GPIO_OUT_OFF:     out_q     <= wdata;
        GPIO_OE_OFF:      oe_q      <= wdata;
        GPIO_INTR_EN_OFF: intr_en_q <= wdata;
        default: ;
      endcase
    end
  end

  // write one to clear; an edge in the same cycle still sets
  assign status_clr = (wr_en && offset_i == GPIO_INTR_STATUS_OFF) ? wdata : '0;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      status_q <= '0;
    end else begin
      status_q <= (status_q & ~status_clr) | rise;
    end
  end

  always_comb begin
    rdata_o = '0;
    case (offset_i)
      GPIO_IN_OFF:          rdata_o[NUM_PINS-1:0] = sync2_q;
      GPIO_OUT_OFF:         rdata_o[NUM_PINS-1:0] = out_q;
      GPIO_OE_OFF:          rdata_o[NUM_PINS-1:0] = oe_q;
      GPIO_INTR_EN_OFF:     rdata_o[NUM_PINS-1:0] = intr_en_q;
      GPIO_INTR_STATUS_OFF: rdata_o[NUM_PINS-1:0] = status_q;
      default: ;
    endcase
  end

  assign pins_o    = out_q;
  assign pins_oe_o = oe_q;
  assign intr_o    = status_q & intr_en_q;

endmodule

/* memory_subsystem.sv */
// banked word RAM behind an APB slave port, one wait state per access
// word address splits into bank (upper bits) and word (lower bits), larger addresses wrap
`timescale 1ns/1ps

module memory_subsystem #(
  parameter int unsigned NUM_BANKS  = mcu_pkg::NUM_BANKS,
  parameter int unsigned BANK_WORDS = mcu_pkg::BANK_WORDS
) (
  input logic   clk_i,
  input logic   rst_n_i,
  apb_if.slave  bus
);
  import mcu_pkg::*;

  localparam int unsigned WORD_BITS = $clog2(BANK_WORDS);
  localparam int unsigned BANK_BITS = $clog2(NUM_BANKS);

  logic [WORD_BITS-1:0] word_idx;
  logic [BANK_BITS-1:0] bank_idx;
  logic                 access;
  logic                 wait_q;
  logic                 wr_en;
  data_t                rdata_q;
  data_t                bank_rdata [NUM_BANKS];

  assign word_idx = bus.paddr[2 +: WORD_BITS];
  assign bank_idx = bus.paddr[2+WORD_BITS +: BANK_BITS];
  assign access   = bus.psel && bus.penable;
  assign wr_en    = access && wait_q && bus.pwrite;

  // high in the second access cycle only
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      wait_q <= 1'b0;
    end else begin
      wait_q <= access && !wait_q;
    end
  end

  for (genvar b = 0; b < NUM_BANKS; b++) begin : g_bank
    data_t mem [BANK_WORDS];

    always_ff @(posedge clk_i) begin
      if (wr_en && bank_idx == BANK_BITS'(b)) begin
        mem[word_idx] <= bus.pwdata;
      end
    end

    assign bank_rdata[b] = mem[word_idx];
  end

  // word is captured during the wait state
  always_ff @(posedge clk_i) begin
    if (access && !wait_q) begin
      rdata_q <= bank_rdata[bank_idx];
    end
  end

  assign bus.prdata  = rdata_q;
  assign bus.pready  = access && wait_q;
  assign bus.pslverr = 1'b0;

endmodule

/* system_bus.sv */
// routes the external APB master to RAM, always-on or peripheral subsystem
// unmapped regions get an error response from here
`timescale 1ns/1ps

module system_bus (
  input  logic           clk_i,
  input  logic           rst_n_i,
  input  mcu_pkg::addr_t paddr_i,
  input  logic           psel_i,
  input  logic           penable_i,
  input  logic           pwrite_i,
  input  mcu_pkg::data_t pwdata_i,
  output mcu_pkg::data_t prdata_o,
  output logic           pready_o,
  output logic           pslverr_o,
  apb_if.master          ram_bus,
  apb_if.master          ao_bus,
  apb_if.master          periph_bus
);
  import mcu_pkg::*;

  // register subsystems see the offset below GPIO_OFFSET and one bit more
  localparam int unsigned OFF_BITS = $clog2(GPIO_OFFSET) + 1;

  region_t region;
  region_t region_q;
  addr_t   reg_offset;

  assign region     = paddr_i[31:28];
  assign reg_offset = addr_t'(paddr_i[OFF_BITS-1:0]);

  // latched in the setup cycle, steers the response path
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      region_q <= REGION_RAM;
    end else if (psel_i && !penable_i) begin
      region_q <= region;
    end
  end

  assign ram_bus.paddr   = paddr_i;
  assign ram_bus.psel    = psel_i && (region == REGION_RAM);
  assign ram_bus.penable = penable_i;
  assign ram_bus.pwrite  = pwrite_i;
  assign ram_bus.pwdata  = pwdata_i;

  assign ao_bus.paddr   = reg_offset;
  assign ao_bus.psel    = psel_i && (region == REGION_AO);
  assign ao_bus.penable = penable_i;
  assign ao_bus.pwrite  = pwrite_i;
  assign ao_bus.pwdata  = pwdata_i;

  assign periph_bus.paddr   = reg_offset;
  assign periph_bus.psel    = psel_i && (region == REGION_PERIPH);
  assign periph_bus.penable = penable_i;
  assign periph_bus.pwrite  = pwrite_i;
  assign periph_bus.pwdata  = pwdata_i;

  always_comb begin
    // unmapped: finish at once with an error
    prdata_o  = '0;
    pready_o  = psel_i && penable_i;
    pslverr_o = psel_i && penable_i;
    case (region_q)
      REGION_RAM: begin
        prdata_o  = ram_bus.prdata;
        pready_o  = ram_bus.pready;
        pslverr_o = ram_bus.pslverr;
      end
      REGION_AO: begin
        prdata_o  = ao_bus.prdata;
        pready_o  = ao_bus.pready;
        pslverr_o = ao_bus.pslverr;
      end
      REGION_PERIPH: begin
        prdata_o  = periph_bus.prdata;
        pready_o  = periph_bus.pready;
        pslverr_o = periph_bus.pslverr;
      end
      default: ;
    endcase
  end

endmodule

/* ao_peripheral_subsystem.sv */
// always-on peripherals: SoC control registers and the 8-pin GPIO
// control registers below GPIO_OFFSET, GPIO block at and above it
`timescale 1ns/1ps

module ao_peripheral_subsystem (
  input  logic                                 clk_i,
  input  logic                                 rst_n_i,
  apb_if.slave                                 bus,
  input  logic                                 boot_select_i,
  output logic                                 exit_valid_o,
  output mcu_pkg::data_t                       exit_value_o,
  input  logic [mcu_pkg::NUM_AO_GPIO-1:0]      gpio_i,
  output logic [mcu_pkg::NUM_AO_GPIO-1:0]      gpio_o,
  output logic [mcu_pkg::NUM_AO_GPIO-1:0]      gpio_oe_o,
  output logic [mcu_pkg::NUM_AO_GPIO-1:0]      gpio_intr_o
);
  import mcu_pkg::*;

  logic  access;
  logic  gpio_hit;
  logic  ctrl_wr;
  logic  exit_valid_q;
  data_t exit_value_q;
  data_t gpio_rdata;

  assign access   = bus.psel && bus.penable;
  assign gpio_hit = bus.paddr >= GPIO_OFFSET;
  assign ctrl_wr  = access && bus.pwrite && !gpio_hit;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      exit_valid_q <= 1'b0;
      exit_value_q <= '0;
    end else if (ctrl_wr) begin
      case (bus.paddr)
        EXIT_VALID_OFF: exit_valid_q <= bus.pwdata[0];
        EXIT_VALUE_OFF: exit_value_q <= bus.pwdata;
        default: ;
      endcase
    end
  end

  gpio_bank #(
    .NUM_PINS(NUM_AO_GPIO)
  ) gpio_ao_i (
    .clk_i,
    .rst_n_i,
    .sel_i    (access && gpio_hit),
    .write_i  (bus.pwrite),
    .offset_i (bus.paddr - GPIO_OFFSET),
    .wdata_i  (bus.pwdata),
    .rdata_o  (gpio_rdata),
    .pins_i   (gpio_i),
    .pins_o   (gpio_o),
    .pins_oe_o(gpio_oe_o),
    .intr_o   (gpio_intr_o)
  );

  always_comb begin
    bus.prdata = '0;
    if (gpio_hit) begin
      bus.prdata = gpio_rdata;
    end else begin
      case (bus.paddr)
        EXIT_VALID_OFF:  bus.prdata[0] = exit_valid_q;
        EXIT_VALUE_OFF:  bus.prdata    = exit_value_q;
        BOOT_SELECT_OFF: bus.prdata[0] = boot_select_i;
        default: ;
      endcase
    end
  end

  // no wait states here
  assign bus.pready  = access;
  assign bus.pslverr = 1'b0;

  assign exit_valid_o = exit_valid_q;
  assign exit_value_o = exit_value_q;

endmodule

/* peripheral_subsystem.sv */
// main peripherals: software interrupt register and the 24-pin GPIO
// GPIO interrupts are ORed into the external interrupt line
`timescale 1ns/1ps

module peripheral_subsystem (
  input  logic                                            clk_i,
  input  logic                                            rst_n_i,
  apb_if.slave                                            bus,
  input  logic [mcu_pkg::NUM_GPIO-mcu_pkg::NUM_AO_GPIO-1:0] gpio_i,
  output logic [mcu_pkg::NUM_GPIO-mcu_pkg::NUM_AO_GPIO-1:0] gpio_o,
  output logic [mcu_pkg::NUM_GPIO-mcu_pkg::NUM_AO_GPIO-1:0] gpio_oe_o,
  output logic                                            irq_software_o,
  output logic                                            irq_external_o
);
  import mcu_pkg::*;

  localparam int unsigned NUM_PINS = NUM_GPIO - NUM_AO_GPIO;

  logic                access;
  logic                gpio_hit;
  logic                msip_q;
  logic [NUM_PINS-1:0] gpio_intr;
  data_t               gpio_rdata;

  assign access   = bus.psel && bus.penable;
  assign gpio_hit = bus.paddr >= GPIO_OFFSET;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      msip_q <= 1'b0;
    end else if (access && bus.pwrite && bus.paddr == MSIP_OFF) begin
      msip_q <= bus.pwdata[0];
    end
  end

  gpio_bank #(
    .NUM_PINS(NUM_PINS)
  ) gpio_i_bank (
    .clk_i,
    .rst_n_i,
    .sel_i    (access && gpio_hit),
    .write_i  (bus.pwrite),
    .offset_i (bus.paddr - GPIO_OFFSET),
    .wdata_i  (bus.pwdata),
    .rdata_o  (gpio_rdata),
    .pins_i   (gpio_i),
    .pins_o   (gpio_o),
    .pins_oe_o(gpio_oe_o),
    .intr_o   (gpio_intr)
  );

  assign bus.prdata  = gpio_hit ? gpio_rdata :
                       (bus.paddr == MSIP_OFF) ? data_t'(msip_q) : '0;
  assign bus.pready  = access;
  assign bus.pslverr = 1'b0;

  assign irq_software_o = msip_q;
  assign irq_external_o = |gpio_intr;

endmodule

/* mini_mcu.sv */
// top level of the reduced MCU fabric, an external APB master stands in for the CPU
// wires bus, memory, both peripheral subsystems, the pins and the interrupt vector
`timescale 1ns/1ps

module mini_mcu #(
  parameter int unsigned NUM_BANKS  = mcu_pkg::NUM_BANKS,
  parameter int unsigned BANK_WORDS = mcu_pkg::BANK_WORDS
) (
  input  logic                          clk_i,
  input  logic                          rst_n_i,
  input  mcu_pkg::addr_t                paddr_i,
  input  logic                          psel_i,
  input  logic                          penable_i,
  input  logic                          pwrite_i,
  input  mcu_pkg::data_t                pwdata_i,
  output mcu_pkg::data_t                prdata_o,
  output logic                          pready_o,
  output logic                          pslverr_o,
  input  logic                          boot_select_i,
  input  logic [mcu_pkg::NUM_GPIO-1:0]  gpio_i,
  output logic [mcu_pkg::NUM_GPIO-1:0]  gpio_o,
  output logic [mcu_pkg::NUM_GPIO-1:0]  gpio_oe_o,
  output logic                          exit_valid_o,
  output mcu_pkg::data_t                exit_value_o,
  output mcu_pkg::intr_t                intr_o
);
  import mcu_pkg::*;

  apb_if ram_bus ();
  apb_if ao_bus ();
  apb_if periph_bus ();

  logic                   irq_software;
  logic                   irq_external;
  logic [NUM_AO_GPIO-1:0] gpio_ao_intr;

  system_bus system_bus_i (
    .clk_i,
    .rst_n_i,
    .paddr_i,
    .psel_i,
    .penable_i,
    .pwrite_i,
    .pwdata_i,
    .prdata_o,
    .pready_o,
    .pslverr_o,
    .ram_bus   (ram_bus.master),
    .ao_bus    (ao_bus.master),
    .periph_bus(periph_bus.master)
  );

  memory_subsystem #(
    .NUM_BANKS (NUM_BANKS),
    .BANK_WORDS(BANK_WORDS)
  ) memory_subsystem_i (
    .clk_i,
    .rst_n_i,
    .bus(ram_bus.slave)
  );

  // pins 7..0 belong to the always-on domain
  ao_peripheral_subsystem ao_peripheral_subsystem_i (
    .clk_i,
    .rst_n_i,
    .bus        (ao_bus.slave),
    .boot_select_i,
    .exit_valid_o,
    .exit_value_o,
    .gpio_i     (gpio_i[NUM_AO_GPIO-1:0]),
    .gpio_o     (gpio_o[NUM_AO_GPIO-1:0]),
    .gpio_oe_o  (gpio_oe_o[NUM_AO_GPIO-1:0]),
    .gpio_intr_o(gpio_ao_intr)
  );

  peripheral_subsystem peripheral_subsystem_i (
    .clk_i,
    .rst_n_i,
    .bus           (periph_bus.slave),
    .gpio_i        (gpio_i[NUM_GPIO-1:NUM_AO_GPIO]),
    .gpio_o        (gpio_o[NUM_GPIO-1:NUM_AO_GPIO]),
    .gpio_oe_o     (gpio_oe_o[NUM_GPIO-1:NUM_AO_GPIO]),
    .irq_software_o(irq_software),
    .irq_external_o(irq_external)
  );

  // timer and uart slots stay zero
  always_comb begin
    intr_o                              = '0;
    intr_o[IRQ_SOFTWARE_BIT]            = irq_software;
    intr_o[IRQ_EXTERNAL_BIT]            = irq_external;
    intr_o[IRQ_FAST_LSB +: NUM_AO_GPIO] = gpio_ao_intr;
  end

endmodule

/* tb_mini_mcu.sv */
// testbench for the mini MCU, replays the records of mcu_cases.txt over APB and the pins
// RAM data words are the record word XORed with a random mask per wrapped word address
`timescale 1ns/1ps

module tb_mini_mcu;

  localparam int unsigned CLK_PERIOD     = 4;
  localparam int unsigned RAM_BANKS      = 4;
  localparam int unsigned RAM_BANK_WORDS = 16;
  localparam int unsigned RAM_WORDS      = RAM_BANKS * RAM_BANK_WORDS;
  localparam int unsigned MASK_BITS      = $clog2(RAM_WORDS);
  localparam int unsigned MAX_WAITS      = 16;
  localparam int unsigned SETTLE_CYCLES  = 5;
  // software, external and the eight fast interrupt bits
  localparam logic [31:0] IRQ_USED = 32'h00FF_0808;

  logic        clk;
  logic        rst_n;
  logic [31:0] paddr;
  logic        psel;
  logic        penable;
  logic        pwrite;
  logic [31:0] pwdata;
  logic [31:0] prdata;
  logic        pready;
  logic        pslverr;
  logic        boot_select;
  logic [31:0] gpio_in;
  logic [31:0] gpio_out;
  logic [31:0] gpio_oe;
  logic        exit_valid;
  logic [31:0] exit_value;
  logic [31:0] intr;

  logic [31:0] ram_mask [RAM_WORDS];
  string       case_op [$];
  logic [31:0] case_a [$];
  logic [31:0] case_d [$];
  logic [31:0] case_e [$];
  int          case_line [$];
  int          num_cases = 0;
  int          case_errors = 0;
  int          monitor_errors = 0;
  int          pass_count = 0;
  int          fail_count = 0;

  mini_mcu #(
    .NUM_BANKS (RAM_BANKS),
    .BANK_WORDS(RAM_BANK_WORDS)
  ) mini_mcu_i (
    .clk_i        (clk),
    .rst_n_i      (rst_n),
    .paddr_i      (paddr),
    .psel_i       (psel),
    .penable_i    (penable),
    .pwrite_i     (pwrite),
    .pwdata_i     (pwdata),
    .prdata_o     (prdata),
    .pready_o     (pready),
    .pslverr_o    (pslverr),
    .boot_select_i(boot_select),
    .gpio_i       (gpio_in),
    .gpio_o       (gpio_out),
    .gpio_oe_o    (gpio_oe),
    .exit_valid_o (exit_valid),
    .exit_value_o (exit_value),
    .intr_o       (intr)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // regions 0, 2 and 3 are mapped, all others answer with an error
  function automatic logic is_mapped(input logic [31:0] addr);
    return addr[31:28] == 4'h0 || addr[31:28] == 4'h2 || addr[31:28] == 4'h3;
  endfunction

  function automatic logic [31:0] ram_word_mask(input logic [31:0] addr);
    logic [MASK_BITS-1:0] idx;
    idx = addr[2 +: MASK_BITS];
    return (addr[31:28] == 4'h0) ? ram_mask[idx] : 32'h0;
  endfunction

  task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (act !== exp) begin
      $display("Mismatch at %0t ns: %s expected %h actual %h", $time, name, exp, act);
      case_errors++;
    end
  endtask

  task automatic apb_transfer(input logic write, input logic [31:0] addr,
                              input logic [31:0] wdata, output logic [31:0] rdata,
                              output logic err);
    int unsigned waits;
    logic        first_ready;
    waits = 0;
    @(negedge clk);
    paddr   = addr;
    pwrite  = write;
    pwdata  = wdata;
    psel    = 1'b1;
    penable = 1'b0;
    @(negedge clk);
    penable = 1'b1;
    #1;
    first_ready = pready;
    while (pready !== 1'b1 && waits < MAX_WAITS) begin
      @(negedge clk);
      #1;
      waits++;
    end
    if (pready !== 1'b1) begin
      $display("no pready for address %h after %0d wait cycles", addr, waits);
      case_errors++;
    end
    // RAM always inserts one wait state
    if (addr[31:28] == 4'h0) begin
      check_value("pready_o in first access cycle", 32'h0, 32'(first_ready));
    end
    rdata = prdata;
    err   = pslverr;
    @(negedge clk);
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  task automatic check_reset_values();
    case_errors = 0;
    @(negedge clk);
    #1;
    check_value("exit_valid_o", 32'h0, 32'(exit_valid));
    check_value("exit_value_o", 32'h0, exit_value);
    check_value("gpio_o", 32'h0, gpio_out);
    check_value("gpio_oe_o", 32'h0, gpio_oe);
    check_value("intr_o", 32'h0, intr);
    check_value("pready_o", 32'h0, 32'(pready));
    check_value("pslverr_o", 32'h0, 32'(pslverr));
    if (case_errors == 0) begin
      pass_count++;
      $display("reset values ok");
    end else begin
      fail_count++;
      $display("reset values failed with %0d errors", case_errors);
    end
  endtask

  task automatic run_case(input int idx);
    string       op;
    logic [31:0] a;
    logic [31:0] d;
    logic [31:0] e;
    logic [31:0] rdata;
    logic        err;
    op = case_op[idx];
    a  = case_a[idx];
    d  = case_d[idx];
    e  = case_e[idx];
    case_errors = 0;
    if (op == "write") begin
      apb_transfer(1'b1, a, d ^ ram_word_mask(a), rdata, err);
      check_value("pslverr_o", 32'(!is_mapped(a)), 32'(err));
    end else if (op == "read") begin
      apb_transfer(1'b0, a, 32'h0, rdata, err);
      check_value("pslverr_o", 32'(!is_mapped(a)), 32'(err));
      check_value("prdata_o", e ^ ram_word_mask(a), rdata);
    end else if (op == "pins") begin
      @(negedge clk);
      gpio_in     = a;
      boot_select = d[0];
      // two synchronizer flops plus the edge stage
      repeat (SETTLE_CYCLES) @(negedge clk);
    end else if (op == "check-pins") begin
      @(negedge clk);
      #1;
      if (a == 32'h0) begin
        check_value("gpio_o", d, gpio_out);
        check_value("gpio_oe_o", e, gpio_oe);
      end else begin
        check_value("exit_valid_o", 32'(d[0]), 32'(exit_valid));
        check_value("exit_value_o", e, exit_value);
      end
    end else if (op == "check-irq") begin
      @(negedge clk);
      #1;
      check_value("intr_o", e, intr);
    end else begin
      $display("unknown operation %s on line %0d of the case file", op, case_line[idx]);
      case_errors++;
    end
    if (case_errors == 0) begin
      pass_count++;
      $display("case %0d (line %0d, %s %h) ok", idx, case_line[idx], op, a);
    end else begin
      fail_count++;
      $display("case %0d (line %0d, %s %h) failed with %0d errors",
               idx, case_line[idx], op, a, case_errors);
    end
  endtask

  // unused interrupt vector bits must never rise
  always @(negedge clk) begin
    if (rst_n && (intr & ~IRQ_USED) !== 32'h0) begin
      $display("Mismatch at %0t ns: intr_o unused bits expected %h actual %h",
               $time, 32'h0, intr & ~IRQ_USED);
      monitor_errors++;
    end
  end

  initial begin
    wait (num_cases > 0);
    #(num_cases * 50 * CLK_PERIOD);
    $display("watchdog expired after %0d cycles before all cases finished", num_cases * 50);
    $display("sim failed");
    $finish;
  end

  initial begin
    int          fd;
    int          n;
    int          line_no;
    string       line;
    string       op;
    logic [31:0] a;
    logic [31:0] d;
    logic [31:0] e;
    rst_n       = 1'b0;
    paddr       = 32'h0;
    psel        = 1'b0;
    penable     = 1'b0;
    pwrite      = 1'b0;
    pwdata      = 32'h0;
    boot_select = 1'b0;
    gpio_in     = 32'h0;
    void'($urandom(4709));
    for (int i = 0; i < RAM_WORDS; i++) begin
      ram_mask[i] = $urandom();
    end

    line_no = 0;
    fd = $fopen("mcu_cases.txt", "r");
    if (fd == 0) begin
      $display("cannot open mcu_cases.txt for reading");
      fail_count++;
    end else begin
      while ($fgets(line, fd) != 0) begin
        line_no++;
        if (line.len() > 1 && line.getc(0) != "#") begin
          n = $sscanf(line, "%s %h %h %h", op, a, d, e);
          if (n == 4) begin
            case_op.push_back(op);
            case_a.push_back(a);
            case_d.push_back(d);
            case_e.push_back(e);
            case_line.push_back(line_no);
          end else begin
            $display("malformed record on line %0d of mcu_cases.txt", line_no);
            fail_count++;
          end
        end
      end
      $fclose(fd);
    end
    num_cases = case_op.size();

    repeat (3) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    check_reset_values();
    for (int i = 0; i < num_cases; i++) begin
      run_case(i);
    end

    $display("cases passed %0d, failed %0d, interrupt monitor errors %0d",
             pass_count, fail_count, monitor_errors);
    if (fail_count == 0 && monitor_errors == 0 && num_cases > 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

/* mcu_cases.txt */
# columns: operation, address or value, data, expected (all hex)
# pins: value = gpio_i, data bit 0 = boot_select; check-pins: value 0 gpio, 1 exit outputs
write 00000000 11111111 0
write 00000044 22222222 0
write 00000088 33333333 0
write 000000FC 44444444 0
read 00000000 0 11111111
read 00000044 0 22222222
read 00000088 0 33333333
read 000000FC 0 44444444
write 00000108 55555555 0
read 00000008 0 55555555
write 10000000 DEADBEEF 0
read 10000000 0 00000000
read 50000004 0 00000000
write 20000004 CAFEF00D 0
write 20000000 00000001 0
check-pins 1 00000001 CAFEF00D
write 20000104 000000A5 0
write 20000108 0000000F 0
write 30000104 00123456 0
write 30000108 00FFFF00 0
check-pins 0 123456A5 FFFF000F
pins 8BADF00D 0 0
read 20000100 0 0000000D
read 30000100 0 008BADF0
pins 00000000 1 0
read 20000008 0 00000001
pins 00000000 0 0
read 20000008 0 00000000
write 20000110 000000FF 0
write 30000110 00FFFFFF 0
write 2000010C 00000004 0
write 3000010C 00000002 0
check-irq 0 0 00000000
pins 00000204 0 0
check-irq 0 0 00040800
pins 00010204 0 0
check-irq 0 0 00040800
read 30000110 0 00000102
write 20000110 00000004 0
check-irq 0 0 00000800
write 30000110 00000002 0
check-irq 0 0 00000000
read 30000110 0 00000100
write 30000000 00000001 0
check-irq 0 0 00000008
read 30000000 0 00000001
write 30000000 00000000 0
check-irq 0 0 00000000

/* flist.f */
mcu_pkg.sv
apb_if.sv
gpio_bank.sv
memory_subsystem.sv
system_bus.sv
ao_peripheral_subsystem.sv
peripheral_subsystem.sv
mini_mcu.sv
tb_mini_mcu.sv

/* Makefile */
# Verilator flow for the mini MCU: make lint, make sim, make clean

VERILATOR ?= verilator
TOP       ?= tb_mini_mcu
RTL_TOP   ?= mini_mcu
SEED      ?= 4709
LOG       ?= sim.log
FLIST     ?= flist.f
VFLAGS    ?= --timescale 1ns/1ps --timing

SRCS := $(shell cat $(FLIST))
BIN  := obj_dir/V$(TOP)

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(RTL_TOP) -f $(FLIST)

$(BIN): $(SRCS) $(FLIST)
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FLIST)

sim: $(BIN)
	./$(BIN) +verilator+seed+$(SEED) > $(LOG) 2>&1; status=$$?; \
	cat $(LOG); \
	if grep -q "sim failed" $(LOG); then exit 1; fi; \
	exit $$status

clean:
	rm -rf obj_dir $(LOG)
